// ==== verilog/nfu_pkg.sv ====
// NFU shared package with widths, Q8.8 arithmetic helpers and the op and state enums
package nfu_pkg;

    // Data format, 16-bit signed with 8 fraction bits
    localparam int DATA_W     = 16;
    localparam int FRAC_BITS  = 8;
    localparam int PROD_W     = 2 * DATA_W;

    // Tile geometry, Tn neurons in and out
    localparam int NEURONS    = 4;
    localparam int VEC_W      = NEURONS * DATA_W;
    localparam int MAT_W      = NEURONS * NEURONS * DATA_W;

    // Run sizes and pipeline timing
    localparam int CNT_W      = 8;
    localparam int PIPE_DEPTH = 4;
    localparam int DRAIN_W    = $clog2(PIPE_DEPTH + 1);

    // Saturation limits of one value
    localparam logic signed [DATA_W-1:0] DATA_MAX = {1'b0, {(DATA_W-1){1'b1}}};
    localparam logic signed [DATA_W-1:0] DATA_MIN = {1'b1, {(DATA_W-1){1'b0}}};

    typedef enum logic {
        OP_SUM = 1'b0,
        OP_MAX = 1'b1
    } nfu_op_e;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_RUN   = 2'd1,
        ST_DRAIN = 2'd2
    } ctrl_state_e;

    // Q8.8 multiply, floor shift then clamp
    function automatic logic signed [DATA_W-1:0] fx_mul(
        input logic signed [DATA_W-1:0] a,
        input logic signed [DATA_W-1:0] b
    );
        logic signed [PROD_W-1:0] prod;
        logic signed [PROD_W-1:0] scaled;
        prod   = a * b;
        // Arithmetic shift rounds toward minus infinity
        scaled = prod >>> FRAC_BITS;
        if (scaled > PROD_W'(DATA_MAX)) begin
            return DATA_MAX;
        end else if (scaled < PROD_W'(DATA_MIN)) begin
            return DATA_MIN;
        end
        return scaled[DATA_W-1:0];
    endfunction

    // Saturating add
    function automatic logic signed [DATA_W-1:0] fx_add(
        input logic signed [DATA_W-1:0] a,
        input logic signed [DATA_W-1:0] b
    );
        logic signed [DATA_W:0] sum;
        sum = a + b;
        // Overflow when the two top bits disagree
        if (sum[DATA_W] != sum[DATA_W-1]) begin
            return sum[DATA_W] ? DATA_MIN : DATA_MAX;
        end
        return sum[DATA_W-1:0];
    endfunction

    function automatic logic signed [DATA_W-1:0] fx_max(
        input logic signed [DATA_W-1:0] a,
        input logic signed [DATA_W-1:0] b
    );
        return (a > b) ? a : b;
    endfunction

endpackage

// ==== verilog/nfu_multiplier_array.sv ====
// NFU-1 multiplier array forming all neuron by synapse products as registered Q8.8 values
module nfu_multiplier_array (
    input  logic                      clk,
    input  logic [nfu_pkg::VEC_W-1:0] i_neurons,
    input  logic [nfu_pkg::MAT_W-1:0] i_synapses,
    output logic [nfu_pkg::MAT_W-1:0] o_products
);
    import nfu_pkg::*;

    // Unregistered products in the same row-major layout as the synapses
    logic [MAT_W-1:0] prod_d;

    for (genvar j = 0; j < NEURONS; j++) begin : g_row
        for (genvar i = 0; i < NEURONS; i++) begin : g_col
            // Element (j,i) sits at row j, column i
            localparam int ELEM = j * NEURONS + i;

            logic signed [DATA_W-1:0] syn;
            logic signed [DATA_W-1:0] neu;

            assign syn = i_synapses[ELEM*DATA_W +: DATA_W];
            // Column i always pairs with input neuron i
            assign neu = i_neurons[i*DATA_W +: DATA_W];
            assign prod_d[ELEM*DATA_W +: DATA_W] = fx_mul(syn, neu);
        end
    end

    // One register stage for the whole array
    // Validity travels alongside in the top level tag pipe
    always_ff @(posedge clk) begin
        o_products <= prod_d;
    end

endmodule

// ==== verilog/nfu_reduce_accumulate.sv ====
// NFU-2 per-row sum or max reduction merged with a partial value into a running accumulator
module nfu_reduce_accumulate (
    input  logic                      clk,
    input  logic                      i_rst,
    input  logic [nfu_pkg::MAT_W-1:0] i_products,
    input  logic [nfu_pkg::VEC_W-1:0] i_partial,
    input  nfu_pkg::nfu_op_e          i_op,
    input  logic                      i_valid,
    input  logic                      i_first,
    input  logic                      i_last,
    output logic [nfu_pkg::VEC_W-1:0] o_acc,
    output logic                      o_group_valid
);
    import nfu_pkg::*;

    // Tags aligned with the registered tree results
    logic valid_q;
    logic first_q;
    logic last_q;

    for (genvar j = 0; j < NEURONS; j++) begin : g_row
        logic signed [DATA_W-1:0] p [NEURONS];
        logic signed [DATA_W-1:0] pair_lo;
        logic signed [DATA_W-1:0] pair_hi;
        logic signed [DATA_W-1:0] red_d;
        logic signed [DATA_W-1:0] red_q;
        logic signed [DATA_W-1:0] part_q;
        logic signed [DATA_W-1:0] acc_q;
        logic signed [DATA_W-1:0] base;
        logic signed [DATA_W-1:0] merged;

        for (genvar i = 0; i < NEURONS; i++) begin : g_col
            assign p[i] = i_products[(j*NEURONS+i)*DATA_W +: DATA_W];
        end

        // Two-level tree over the four products of row j
        // Sum saturates at every adder
        assign pair_lo = (i_op == OP_SUM) ? fx_add(p[0], p[1]) : fx_max(p[0], p[1]);
        assign pair_hi = (i_op == OP_SUM) ? fx_add(p[2], p[3]) : fx_max(p[2], p[3]);
        assign red_d   = (i_op == OP_SUM) ? fx_add(pair_lo, pair_hi) : fx_max(pair_lo, pair_hi);

        // Tree result and partial wait one cycle before the merge
        always_ff @(posedge clk) begin
            red_q  <= red_d;
            part_q <= i_partial[j*DATA_W +: DATA_W];
        end

        // First tile of a group starts from NBout, later ones from the running value
        assign base   = first_q ? part_q : acc_q;
        assign merged = (i_op == OP_SUM) ? fx_add(base, red_q) : fx_max(base, red_q);

        always_ff @(posedge clk) begin
            if (valid_q) begin
                acc_q <= merged;
            end
        end

        assign o_acc[j*DATA_W +: DATA_W] = acc_q;
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            valid_q       <= 1'b0;
            first_q       <= 1'b0;
            last_q        <= 1'b0;
            o_group_valid <= 1'b0;
        end else begin
            valid_q       <= i_valid;
            first_q       <= i_first;
            last_q        <= i_last;
            // Group is complete once its last tile has been merged
            o_group_valid <= valid_q && last_q;
        end
    end

    // Tags arrive from the controller through the top level pipe
    a_tags_need_valid : assert property (
        @(posedge clk) disable iff (i_rst) (i_first || i_last) |-> i_valid
    );

endmodule

// ==== verilog/nfu_tile_counter.sv ====
// Tile and group position counter with a pipeline drain timer
module nfu_tile_counter (
    input  logic                      clk,
    input  logic                      i_rst,
    input  logic                      i_load,
    input  logic [nfu_pkg::CNT_W-1:0] i_tiles,
    input  logic [nfu_pkg::CNT_W-1:0] i_groups,
    input  logic                      i_step,
    input  logic                      i_drain_start,
    output logic                      o_first,
    output logic                      o_last,
    output logic                      o_final,
    output logic                      o_drain_done
);
    import nfu_pkg::*;

    logic [CNT_W-1:0]   tile_q;
    logic [CNT_W-1:0]   group_q;
    logic [CNT_W-1:0]   tiles_lim_q;
    logic [CNT_W-1:0]   groups_lim_q;
    logic               run_done_q;
    logic [DRAIN_W-1:0] drain_q;

    // Position flags straight from the registers
    assign o_first = (tile_q == '0);
    assign o_last  = (tile_q == tiles_lim_q - CNT_W'(1));
    assign o_final = o_last && (group_q == groups_lim_q - CNT_W'(1));

    always_ff @(posedge clk) begin
        if (i_rst) begin
            tile_q       <= '0;
            group_q      <= '0;
            tiles_lim_q  <= CNT_W'(1);
            groups_lim_q <= CNT_W'(1);
            run_done_q   <= 1'b0;
        end else if (i_load) begin
            tile_q       <= '0;
            group_q      <= '0;
            tiles_lim_q  <= i_tiles;
            groups_lim_q <= i_groups;
            run_done_q   <= 1'b0;
        end else if (i_step && !run_done_q) begin
            // Wrap the tile index into the next group
            if (o_last) begin
                tile_q  <= '0;
                group_q <= group_q + CNT_W'(1);
            end else begin
                tile_q  <= tile_q + CNT_W'(1);
            end
            if (o_final) begin
                run_done_q <= 1'b1;
            end
        end
    end

    // Drain timer covers the tiles still in flight
    always_ff @(posedge clk) begin
        if (i_rst) begin
            drain_q <= '0;
        end else if (i_drain_start) begin
            drain_q <= DRAIN_W'(PIPE_DEPTH);
        end else if (drain_q != '0) begin
            drain_q <= drain_q - DRAIN_W'(1);
        end
    end

    assign o_drain_done = (drain_q == '0);

    // Controller must stop stepping after the final tile until it reloads
    a_no_step_after_final : assert property (
        @(posedge clk) disable iff (i_rst) (run_done_q && !i_load) |-> !i_step
    );

endmodule

// ==== verilog/nfu_layer_ctrl.sv ====
// Layer controller FSM that starts a run, tags accepted tiles and signals the end of the run
module nfu_layer_ctrl (
    input  logic             clk,
    input  logic             i_rst,
    input  logic             i_start,
    input  logic             i_valid,
    input  nfu_pkg::nfu_op_e i_op,
    input  logic             i_first,
    input  logic             i_last,
    input  logic             i_final,
    input  logic             i_drain_done,
    output logic             o_load,
    output logic             o_step,
    output logic             o_drain_start,
    output logic             o_accept,
    output logic             o_first,
    output logic             o_last,
    output nfu_pkg::nfu_op_e o_op,
    output logic             o_busy,
    output logic             o_done
);
    import nfu_pkg::*;

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    nfu_op_e     op_q;

    always_comb begin
        state_d       = state_q;
        o_load        = 1'b0;
        o_accept      = 1'b0;
        o_drain_start = 1'b0;
        o_done        = 1'b0;
        case (state_q)
            ST_IDLE: begin
                // Start and its sizes only count here
                if (i_start) begin
                    o_load  = 1'b1;
                    state_d = ST_RUN;
                end
            end
            ST_RUN: begin
                o_accept = i_valid;
                if (i_valid && i_final) begin
                    o_drain_start = 1'b1;
                    state_d       = ST_DRAIN;
                end
            end
            ST_DRAIN: begin
                // Timer hits zero together with the last o_valid
                if (i_drain_done) begin
                    o_done  = 1'b1;
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    // Tags only for tiles actually taken
    assign o_step  = o_accept;
    assign o_first = o_accept && i_first;
    assign o_last  = o_accept && i_last;
    assign o_op    = op_q;
    assign o_busy  = (state_q != ST_IDLE);

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state_q <= ST_IDLE;
            op_q    <= OP_SUM;
        end else begin
            state_q <= state_d;
            if (o_load) begin
                op_q <= i_op;
            end
        end
    end

    // Tiles only enter the pipe during a run
    a_accept_in_run : assert property (
        @(posedge clk) disable iff (i_rst) o_accept |-> (state_q == ST_RUN)
    );

endmodule

// ==== verilog/nfu_node_top.sv ====
// NFU node top joining the controller, counter, NFU-1 and NFU-2 with the pipeline registers
module nfu_node_top (
    input  logic                      clk,
    input  logic                      i_rst,
    input  logic                      i_start,
    input  logic                      i_valid,
    input  nfu_pkg::nfu_op_e          i_op,
    input  logic [nfu_pkg::CNT_W-1:0] i_tiles,
    input  logic [nfu_pkg::CNT_W-1:0] i_groups,
    input  logic [nfu_pkg::VEC_W-1:0] i_inputs,
    input  logic [nfu_pkg::VEC_W-1:0] i_nbout,
    input  logic [nfu_pkg::MAT_W-1:0] i_synapses,
    output logic [nfu_pkg::VEC_W-1:0] o_to_nbout,
    output logic                      o_valid,
    output logic                      o_busy,
    output logic                      o_done
);
    import nfu_pkg::*;

    // Controller and counter handshake
    logic    load;
    logic    step;
    logic    drain_start;
    logic    drain_done;
    logic    cnt_first;
    logic    cnt_last;
    logic    cnt_final;
    logic    accept;
    logic    tag_first;
    logic    tag_last;
    nfu_op_e op;

    // Stage 1 payload and tags
    logic [VEC_W-1:0] s1_inputs;
    logic [MAT_W-1:0] s1_synapses;
    logic [VEC_W-1:0] s1_nbout;
    logic             s1_valid;
    logic             s1_first;
    logic             s1_last;

    // Stage 2 partial and tags, matching the product register
    logic [VEC_W-1:0] s2_nbout;
    logic             s2_valid;
    logic             s2_first;
    logic             s2_last;

    logic [MAT_W-1:0] products;
    logic [VEC_W-1:0] acc;
    logic             group_valid;

    nfu_layer_ctrl ctrl0 (
        .clk           (clk),
        .i_rst         (i_rst),
        .i_start       (i_start),
        .i_valid       (i_valid),
        .i_op          (i_op),
        .i_first       (cnt_first),
        .i_last        (cnt_last),
        .i_final       (cnt_final),
        .i_drain_done  (drain_done),
        .o_load        (load),
        .o_step        (step),
        .o_drain_start (drain_start),
        .o_accept      (accept),
        .o_first       (tag_first),
        .o_last        (tag_last),
        .o_op          (op),
        .o_busy        (o_busy),
        .o_done        (o_done)
    );

    nfu_tile_counter cnt0 (
        .clk           (clk),
        .i_rst         (i_rst),
        .i_load        (load),
        .i_tiles       (i_tiles),
        .i_groups      (i_groups),
        .i_step        (step),
        .i_drain_start (drain_start),
        .o_first       (cnt_first),
        .o_last        (cnt_last),
        .o_final       (cnt_final),
        .o_drain_done  (drain_done)
    );

    // Payload registers carry no reset
    always_ff @(posedge clk) begin
        s1_inputs   <= i_inputs;
        s1_synapses <= i_synapses;
        s1_nbout    <= i_nbout;
        s2_nbout    <= s1_nbout;
    end

    // Tag pipe, dropped tiles enter as invalid
    always_ff @(posedge clk) begin
        if (i_rst) begin
            s1_valid <= 1'b0;
            s1_first <= 1'b0;
            s1_last  <= 1'b0;
            s2_valid <= 1'b0;
            s2_first <= 1'b0;
            s2_last  <= 1'b0;
        end else begin
            s1_valid <= accept;
            s1_first <= tag_first;
            s1_last  <= tag_last;
            s2_valid <= s1_valid;
            s2_first <= s1_first;
            s2_last  <= s1_last;
        end
    end

    nfu_multiplier_array nfu1 (
        .clk        (clk),
        .i_neurons  (s1_inputs),
        .i_synapses (s1_synapses),
        .o_products (products)
    );

    nfu_reduce_accumulate nfu2 (
        .clk           (clk),
        .i_rst         (i_rst),
        .i_products    (products),
        .i_partial     (s2_nbout),
        .i_op          (op),
        .i_valid       (s2_valid),
        .i_first       (s2_first),
        .i_last        (s2_last),
        .o_acc         (acc),
        .o_group_valid (group_valid)
    );

    // Output register toward NBout
    // Captures the accumulator before the next group overwrites it
    always_ff @(posedge clk) begin
        if (group_valid) begin
            o_to_nbout <= acc;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= group_valid;
        end
    end

endmodule

// ==== verif/nfu_node_tb.sv ====
// Testbench for the NFU node with LCG stimulus, a reference model and a result scoreboard
module nfu_node_tb;
    import nfu_pkg::*;

    // Deepest group that any run below sends
    localparam int MAX_TILES = 8;

    logic             clk = 1'b0;
    logic             i_rst;
    logic             i_start;
    logic             i_valid;
    nfu_op_e          i_op;
    logic [CNT_W-1:0] i_tiles;
    logic [CNT_W-1:0] i_groups;
    logic [VEC_W-1:0] i_inputs;
    logic [VEC_W-1:0] i_nbout;
    logic [MAT_W-1:0] i_synapses;
    logic [VEC_W-1:0] o_to_nbout;
    logic             o_valid;
    logic             o_busy;
    logic             o_done;

    // Tiles of the group in flight, read by the reference model
    logic [VEC_W-1:0] tile_in  [MAX_TILES];
    logic [MAT_W-1:0] tile_syn [MAX_TILES];

    // Scoreboard entries in group order
    logic [VEC_W-1:0] exp_data_q  [$];
    int               exp_cycle_q [$];
    bit               exp_final_q [$];

    logic [31:0] lcg_state   = 32'h5ce1_114b;
    int          cycle_cnt   = 0;
    int          errors      = 0;
    int          timeouts    = 0;
    // High while no run is active
    bit          expect_idle = 1'b0;

    nfu_node_top dut0 (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_start    (i_start),
        .i_valid    (i_valid),
        .i_op       (i_op),
        .i_tiles    (i_tiles),
        .i_groups   (i_groups),
        .i_inputs   (i_inputs),
        .i_nbout    (i_nbout),
        .i_synapses (i_synapses),
        .o_to_nbout (o_to_nbout),
        .o_valid    (o_valid),
        .o_busy     (o_busy),
        .o_done     (o_done)
    );

    always #10 clk = ~clk;

    // Edge count, used to time o_valid
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [DATA_W-1:0] sat16(input longint v);
        if (v > 32767) begin
            return 16'h7fff;
        end else if (v < -32768) begin
            return 16'h8000;
        end
        return 16'(v);
    endfunction

    // Q8.8 product, floor of the scaled value then clamp
    function automatic logic [DATA_W-1:0] q_mul(
        input logic [DATA_W-1:0] a,
        input logic [DATA_W-1:0] b
    );
        longint prod;
        longint scale;
        longint quo;
        prod  = longint'($signed(a)) * longint'($signed(b));
        scale = longint'(1) << FRAC_BITS;
        if (prod >= 0) begin
            quo = prod / scale;
        end else begin
            quo = -((-prod + scale - 1) / scale);
        end
        return sat16(quo);
    endfunction

    function automatic logic [DATA_W-1:0] q_add(
        input logic [DATA_W-1:0] a,
        input logic [DATA_W-1:0] b
    );
        return sat16(longint'($signed(a)) + longint'($signed(b)));
    endfunction

    function automatic logic [DATA_W-1:0] q_max(
        input logic [DATA_W-1:0] a,
        input logic [DATA_W-1:0] b
    );
        return ($signed(a) > $signed(b)) ? a : b;
    endfunction

    // Expected group result over the stored tiles
    function automatic logic [VEC_W-1:0] ref_group(
        input nfu_op_e          op,
        input logic [VEC_W-1:0] part,
        input int               n
    );
        logic [VEC_W-1:0]  res;
        logic [DATA_W-1:0] acc;
        logic [DATA_W-1:0] red;
        logic [DATA_W-1:0] p [NEURONS];
        for (int j = 0; j < NEURONS; j++) begin
            acc = part[j*DATA_W +: DATA_W];
            for (int t = 0; t < n; t++) begin
                for (int i = 0; i < NEURONS; i++) begin
                    p[i] = q_mul(tile_syn[t][(j*NEURONS+i)*DATA_W +: DATA_W],
                                 tile_in[t][i*DATA_W +: DATA_W]);
                end
                // Pairwise order, each add saturates on its own
                if (op == OP_SUM) begin
                    red = q_add(q_add(p[0], p[1]), q_add(p[2], p[3]));
                    acc = q_add(acc, red);
                end else begin
                    red = q_max(q_max(p[0], p[1]), q_max(p[2], p[3]));
                    acc = q_max(acc, red);
                end
            end
            res[j*DATA_W +: DATA_W] = acc;
        end
        return res;
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("Mismatch at time %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // Kind 0 small with rare extremes, 1 negative, 2 full scale
    task automatic rand_value(input int kind, output logic [DATA_W-1:0] v);
        logic [31:0] r;
        lcg_state = lcg_step(lcg_state);
        r = lcg_state;
        if (kind == 2) begin
            v = r[31] ? 16'h7fff : 16'h8000;
        end else if (kind == 1) begin
            // Down to -2.0, never zero
            v = {7'h7f, r[24:16]};
        end else if (r[31:28] == 4'h0) begin
            v = r[27] ? 16'h7fff : 16'h8000;
        end else begin
            v = {{6{r[25]}}, r[25:16]};
        end
    endtask

    task automatic rand_vec(input int kind, output logic [VEC_W-1:0] vec);
        logic [DATA_W-1:0] v;
        for (int i = 0; i < NEURONS; i++) begin
            rand_value(kind, v);
            vec[i*DATA_W +: DATA_W] = v;
        end
    endtask

    task automatic rand_mat(input int kind, output logic [MAT_W-1:0] mat);
        logic [DATA_W-1:0] v;
        for (int i = 0; i < NEURONS * NEURONS; i++) begin
            rand_value(kind, v);
            mat[i*DATA_W +: DATA_W] = v;
        end
    endtask

    // Bounded wait for the run to end and the scoreboard to drain
    task automatic wait_idle(input string what);
        int n;
        n = 0;
        while ((o_busy || exp_data_q.size() != 0) && n < 40) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (o_busy || exp_data_q.size() != 0) begin
            $display("Timeout at time %0t: %s did not finish within 40 cycles", $time, what);
            timeouts++;
        end
    endtask

    // Valid tiles with no run active must vanish
    task automatic send_idle_tiles(input int n);
        logic [VEC_W-1:0] vec;
        logic [MAT_W-1:0] mat;
        for (int k = 0; k < n; k++) begin
            @(posedge clk);
            #2;
            rand_vec(0, vec);
            rand_mat(0, mat);
            i_inputs   = vec;
            i_synapses = mat;
            i_nbout    = vec;
            i_valid    = 1'b1;
        end
        @(posedge clk);
        #2;
        i_valid = 1'b0;
        repeat (PIPE_DEPTH + 2) @(posedge clk);
        #2;
    endtask

    // One run, noise adds a bubble, a stray start and tiles during the drain
    task automatic do_run(
        input nfu_op_e op,
        input int      tiles,
        input int      groups,
        input int      data_kind,
        input int      part_kind,
        input bit      noise
    );
        logic [VEC_W-1:0] vec;
        logic [VEC_W-1:0] part;
        logic [VEC_W-1:0] grp_part;
        logic [MAT_W-1:0] mat;
        @(posedge clk);
        #2;
        expect_idle = 1'b0;
        i_start     = 1'b1;
        i_op        = op;
        i_tiles     = CNT_W'(tiles);
        i_groups    = CNT_W'(groups);
        for (int g = 0; g < groups; g++) begin
            for (int t = 0; t < tiles; t++) begin
                if (noise && g == 1 && t == 0) begin
                    @(posedge clk);
                    #2;
                    i_start = 1'b0;
                    i_valid = 1'b0;
                end
                @(posedge clk);
                #2;
                rand_vec(data_kind, vec);
                rand_mat(data_kind, mat);
                rand_vec(part_kind, part);
                i_start     = 1'b0;
                i_inputs    = vec;
                i_synapses  = mat;
                i_nbout     = part;
                i_valid     = 1'b1;
                tile_in[t]  = vec;
                tile_syn[t] = mat;
                // Only the first tile's partial counts
                if (t == 0) begin
                    grp_part = part;
                end
                if (noise && t == 1) begin
                    i_start  = 1'b1;
                    i_op     = OP_MAX;
                    i_tiles  = 8'd7;
                    i_groups = 8'd9;
                end
                if (t == tiles - 1) begin
                    exp_data_q.push_back(ref_group(op, grp_part, tiles));
                    // Sampled on the next edge, then PIPE_DEPTH edges to o_valid
                    exp_cycle_q.push_back(cycle_cnt + PIPE_DEPTH + 1);
                    exp_final_q.push_back(g == groups - 1);
                end
            end
        end
        if (noise) begin
            for (int k = 0; k < 3; k++) begin
                @(posedge clk);
                #2;
                rand_vec(0, vec);
                rand_mat(0, mat);
                i_inputs   = vec;
                i_synapses = mat;
                i_valid    = 1'b1;
                i_start    = (k == 1);
            end
        end
        @(posedge clk);
        #2;
        i_valid = 1'b0;
        i_start = 1'b0;
        wait_idle("run");
        expect_idle = 1'b1;
    endtask

    // Scoreboard, sampled mid-cycle where outputs are settled
    always @(negedge clk) begin : compare_proc
        logic [VEC_W-1:0] exp_val;
        int               exp_cyc;
        bit               exp_fin;
        bit               idle_next;
        if (!i_rst) begin
            if (idle_next || expect_idle) begin
                check("o_busy", 64'(o_busy), 64'd0);
            end
            idle_next = 1'b0;
            if (o_valid) begin
                if (exp_data_q.size() == 0) begin
                    $display("Error at time %0t: o_valid rose with no group result pending",
                             $time);
                    errors++;
                end else begin
                    exp_val = exp_data_q.pop_front();
                    exp_cyc = exp_cycle_q.pop_front();
                    exp_fin = exp_final_q.pop_front();
                    check("o_to_nbout", o_to_nbout, exp_val);
                    check("o_valid_cycle", 64'(cycle_cnt), 64'(exp_cyc));
                    check("o_done", 64'(o_done), 64'(exp_fin));
                    check("o_busy", 64'(o_busy), 64'd1);
                    // Busy falls one cycle after done
                    idle_next = exp_fin;
                end
            end else begin
                check("o_done", 64'(o_done), 64'd0);
            end
        end
    end

    initial begin
        i_rst      = 1'b1;
        i_start    = 1'b0;
        i_valid    = 1'b0;
        i_op       = OP_SUM;
        i_tiles    = 8'd1;
        i_groups   = 8'd1;
        i_inputs   = '0;
        i_nbout    = '0;
        i_synapses = '0;
        repeat (10) @(posedge clk);
        #2;
        i_rst       = 1'b0;
        expect_idle = 1'b1;

        send_idle_tiles(6);
        // Sum with noise, then max over negative partials
        do_run(OP_SUM, 2, 3, 0, 0, 1'b1);
        do_run(OP_MAX, 3, 2, 0, 1, 1'b0);
        // Full-scale data for clamped products and sums
        do_run(OP_SUM, 2, 2, 2, 2, 1'b0);
        do_run(OP_MAX, 1, 2, 2, 1, 1'b0);
        // One tile per group, back to back
        do_run(OP_SUM, 1, 5, 0, 0, 1'b0);
        repeat (4) @(posedge clk);

        $display("Run complete with %0d check errors and %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
verilog/nfu_pkg.sv
verilog/nfu_multiplier_array.sv
verilog/nfu_reduce_accumulate.sv
verilog/nfu_tile_counter.sv
verilog/nfu_layer_ctrl.sv
verilog/nfu_node_top.sv
verif/nfu_node_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the NFU node testbench with Verilator
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module nfu_node_tb \
    --Mdir "$BUILD_DIR" \
    -f filelist.f

"./$BUILD_DIR/Vnfu_node_tb" | tee "$LOG"

if grep -q "Test failures found" "$LOG"; then
    echo "Simulation FAILED"
    exit 1
fi

echo "Simulation PASSED"
